//--- heapConfigPkg.sv
/*
  Heap dimensions, plus the element, index, size and
  array-number types built from them
*/
package heapConfigPkg;

  // --------------------
  // Dimensions
  localparam int arrayNumberBits = 3;                       // 8 arrays
  localparam int indexBits       = 3;                       // 8 slots per array
  localparam int dataBits        = 12;                      // Element width
  localparam int arrayCount      = 1 << arrayNumberBits;    // Arrays in the heap
  localparam int arrayLength     = 1 << indexBits;          // Slots per array

  // --------------------
  // Types
  typedef logic [arrayNumberBits-1:0] arrayNumber;          // Names one array
  typedef logic [indexBits-1:0]       elementIndex;         // Slot within an array
  typedef logic [dataBits-1:0]        elementData;          // One element
  typedef logic [indexBits:0]         arraySize;            // Extra bit so it can hold arrayLength

endpackage

//--- heapOpsPkg.sv
/*
  Command codes seen by the caller, error codes returned,
  and the internal size-table and element-update operations
*/
package heapOpsPkg;

  // --------------------
  // Caller side
  typedef enum logic [7:0] {
    idle     = 8'd0,                                        // No command
    write,                                                  // Store, extend size to index+1
    read,                                                   // Fetch below size
    size,                                                   // Current size
    push,                                                   // Append at end
    pop,                                                    // Remove from end
    alloc,                                                  // Claim an array
    free,                                                   // Release an array
    add,                                                    // Returns new value
    addAfter,                                               // Returns old value
    subtract,                                               // Returns new value
    subAfter,                                               // Returns old value
    bitAnd,
    bitOr,
    bitXor
  } heapAction;

  typedef enum logic [2:0] {
    none,                                                   // Command succeeded or idle
    notAllocated,                                           // Array free or never claimed
    outOfBounds,                                            // Index at or past size
    arrayFull,                                              // Push with size at arrayLength
    arrayEmpty,                                             // Pop with size zero
    outOfMemory                                             // No array left to allocate
  } heapError;

  // --------------------
  // Internal block controls
  typedef enum logic [2:0] {keep, extendTo, grow, shrink, clear} sizeOp;

  typedef enum logic [2:0] {
    opStore, opAdd, opSubtract, opAnd, opOr, opXor          // Element update kinds
  } updateOp;

endpackage

//--- arrayAllocator.sv
`timescale 1ns/1ns
/*
  Array allocator with a stack of released array numbers,
  a fresh-number counter and one allocated flag per array
*/
module arrayAllocator (
  input  logic                      clock,
  input  logic                      reset,                  // Active low
  input  logic                      allocRequest,           // Claim grantId this edge
  input  logic                      freeRequest,            // Release freeId this edge
  input  heapConfigPkg::arrayNumber queryId,
  input  heapConfigPkg::arrayNumber freeId,
  output logic                      queryAllocated,         // Flag of queryId
  output heapConfigPkg::arrayNumber grantId,                // Next number handed out
  output logic                      grantValid              // Some array still available
);

  heapConfigPkg::arrayNumber               freeStack [heapConfigPkg::arrayCount]; // Released
  logic [heapConfigPkg::arrayNumberBits:0] stackTop;        // Entries on free stack
  logic [heapConfigPkg::arrayNumberBits:0] freshCount;      // Numbers used so far
  logic [heapConfigPkg::arrayCount-1:0]    allocated;       // One flag per array
  logic                                    stackLoaded;     // Free stack not empty
  heapConfigPkg::arrayNumber               topIndex;        // Slot of top entry

  assign stackLoaded    = stackTop != '0;
  assign topIndex       = heapConfigPkg::arrayNumber'(stackTop - 1'b1);
  assign queryAllocated = allocated[queryId];
  assign grantValid     = stackLoaded || (freshCount < heapConfigPkg::arrayCount);

  // Most recently freed number wins over a fresh one
  assign grantId = stackLoaded ? freeStack[topIndex]
                               : heapConfigPkg::arrayNumber'(freshCount);

  // --------------------
  // Counters and flags
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      stackTop   <= '0;
      freshCount <= '0;
      allocated  <= '0;
    end else if (allocRequest) begin
      if (stackLoaded) begin
        stackTop <= stackTop - 1'b1;                        // Pop released number
      end else begin
        freshCount <= freshCount + 1'b1;                    // Hand out next fresh one
      end
      allocated[grantId] <= 1'b1;
    end else if (freeRequest) begin
      stackTop          <= stackTop + 1'b1;
      allocated[freeId] <= 1'b0;
    end
  end

  // Stack storage
  always_ff @(posedge clock) begin
    if (freeRequest) begin
      freeStack[stackTop[heapConfigPkg::arrayNumberBits-1:0]] <= freeId;
    end
  end

endmodule

//--- arraySizeTable.sv
`timescale 1ns/1ns
/*
  Per-array size table with a combinational
  read port and one update per cycle
*/
module arraySizeTable (
  input  logic                       clock,
  input  logic                       reset,                 // Active low
  input  heapConfigPkg::arrayNumber  queryId,               // Array to read out
  input  heapOpsPkg::sizeOp          sizeCommand,           // Update to apply
  input  heapConfigPkg::arrayNumber  sizeTarget,            // Array to update
  input  heapConfigPkg::elementIndex extendIndex,           // Written slot for extendTo
  output heapConfigPkg::arraySize    currentSize            // Size of queryId
);

  heapConfigPkg::arraySize sizes [heapConfigPkg::arrayCount]; // One size per array
  heapConfigPkg::arraySize targetSize;                       // Size of sizeTarget now
  heapConfigPkg::arraySize extended;                         // extendIndex plus one

  assign currentSize = sizes[queryId];
  assign targetSize  = sizes[sizeTarget];
  assign extended    = heapConfigPkg::arraySize'(extendIndex) + 1'b1;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < heapConfigPkg::arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      case (sizeCommand)
        heapOpsPkg::extendTo: begin
          if (targetSize < extended) begin
            sizes[sizeTarget] <= extended;                  // Only ever raises
          end
        end
        heapOpsPkg::grow:   sizes[sizeTarget] <= targetSize + 1'b1;
        heapOpsPkg::shrink: sizes[sizeTarget] <= targetSize - 1'b1;
        heapOpsPkg::clear:  sizes[sizeTarget] <= '0;        // Fresh allocation
        default: ;                                          // Keep
      endcase
    end
  end

endmodule

//--- elementStore.sv
`timescale 1ns/1ns
/*
  Two-dimensional element memory with the
  in-place update arithmetic on the addressed slot
*/
module elementStore (
  input  logic                       clock,
  input  heapConfigPkg::arrayNumber  arrayId,
  input  heapConfigPkg::elementIndex slot,
  input  logic                       writeEnable,           // Store newValue this edge
  input  heapOpsPkg::updateOp        update,
  input  heapConfigPkg::elementData  operand,
  output heapConfigPkg::elementData  oldValue,              // Slot before this edge
  output heapConfigPkg::elementData  newValue               // Slot after this edge
);

  heapConfigPkg::elementData memory [heapConfigPkg::arrayCount][heapConfigPkg::arrayLength];

  assign oldValue = memory[arrayId][slot];

  // --------------------
  // Update arithmetic, wraps at element width
  always_comb begin
    case (update)
      heapOpsPkg::opAdd:      newValue = oldValue + operand;
      heapOpsPkg::opSubtract: newValue = oldValue - operand;
      heapOpsPkg::opAnd:      newValue = oldValue & operand;
      heapOpsPkg::opOr:       newValue = oldValue | operand;
      heapOpsPkg::opXor:      newValue = oldValue ^ operand;
      default:                newValue = operand;           // Plain store
    endcase
  end

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[arrayId][slot] <= newValue;
    end
  end

endmodule

//--- heapMemory.sv
`timescale 1ns/1ns
/*
  Array heap top level. Decodes commands, checks access,
  steers allocator, size table and element store, registers results
*/
module heapMemory (
  input  logic                       clock,
  input  logic                       reset,                 // Active low
  input  heapOpsPkg::heapAction      action,                // One command per cycle
  input  heapConfigPkg::arrayNumber  arrayId,
  input  heapConfigPkg::elementIndex index,
  input  heapConfigPkg::elementData  dataIn,
  output heapConfigPkg::elementData  dataOut,               // Valid one cycle after command
  output heapOpsPkg::heapError       errorCode
);

  logic                       allocated;                    // arrayId currently claimed
  heapConfigPkg::arrayNumber  grantId;
  logic                       grantValid;
  logic                       allocRequest;
  logic                       freeRequest;
  heapOpsPkg::sizeOp          sizeCommand;
  heapConfigPkg::arrayNumber  sizeTarget;
  heapConfigPkg::arraySize    currentSize;
  logic                       writeEnable;
  heapOpsPkg::updateOp        update;
  heapConfigPkg::elementIndex slot;
  heapConfigPkg::elementData  oldValue;
  heapConfigPkg::elementData  newValue;
  heapOpsPkg::heapError       checkError;                   // Outcome of this command
  logic                       accepted;                     // Command passes all checks
  logic                       isUpdate;                     // Any in-place arithmetic
  logic                       inBounds;                     // index below current size

  arrayAllocator arrayAllocator_inst (
    .clock          (clock),
    .reset          (reset),
    .allocRequest   (allocRequest),
    .freeRequest    (freeRequest),
    .queryId        (arrayId),
    .freeId         (arrayId),
    .queryAllocated (allocated),
    .grantId        (grantId),
    .grantValid     (grantValid)
  );

  arraySizeTable arraySizeTable_inst (
    .clock       (clock),
    .reset       (reset),
    .queryId     (arrayId),
    .sizeCommand (sizeCommand),
    .sizeTarget  (sizeTarget),
    .extendIndex (index),
    .currentSize (currentSize)
  );

  elementStore elementStore_inst (
    .clock       (clock),
    .arrayId     (arrayId),
    .slot        (slot),
    .writeEnable (writeEnable),
    .update      (update),
    .operand     (dataIn),
    .oldValue    (oldValue),
    .newValue    (newValue)
  );

  // --------------------
  // Access checks
  assign isUpdate = action inside {heapOpsPkg::add, heapOpsPkg::addAfter,
                                   heapOpsPkg::subtract, heapOpsPkg::subAfter,
                                   heapOpsPkg::bitAnd, heapOpsPkg::bitOr, heapOpsPkg::bitXor};
  assign inBounds = heapConfigPkg::arraySize'(index) < currentSize;

  always_comb begin
    checkError = heapOpsPkg::none;
    case (action)
      heapOpsPkg::idle: ;
      heapOpsPkg::alloc: begin
        if (!grantValid) begin
          checkError = heapOpsPkg::outOfMemory;
        end
      end
      default: begin
        if (!allocated) begin
          checkError = heapOpsPkg::notAllocated;            // Covers a second free too
        end else if ((action == heapOpsPkg::read || isUpdate) && !inBounds) begin
          checkError = heapOpsPkg::outOfBounds;
        end else if (action == heapOpsPkg::push && currentSize == heapConfigPkg::arrayLength) begin
          checkError = heapOpsPkg::arrayFull;
        end else if (action == heapOpsPkg::pop && currentSize == '0) begin
          checkError = heapOpsPkg::arrayEmpty;
        end
      end
    endcase
  end

  assign accepted = (checkError == heapOpsPkg::none) && (action != heapOpsPkg::idle);

  // --------------------
  // Block steering
  assign allocRequest = accepted && action == heapOpsPkg::alloc;
  assign freeRequest  = accepted && action == heapOpsPkg::free;
  assign writeEnable  = accepted && (action inside {heapOpsPkg::write, heapOpsPkg::push}
                                     || isUpdate);
  assign sizeTarget   = (action == heapOpsPkg::alloc) ? grantId : arrayId;

  always_comb begin
    sizeCommand = heapOpsPkg::keep;
    if (accepted) begin
      case (action)
        heapOpsPkg::write: sizeCommand = heapOpsPkg::extendTo;
        heapOpsPkg::push:  sizeCommand = heapOpsPkg::grow;
        heapOpsPkg::pop:   sizeCommand = heapOpsPkg::shrink;
        heapOpsPkg::alloc: sizeCommand = heapOpsPkg::clear;  // New array starts empty
        default: ;
      endcase
    end
  end

  always_comb begin
    case (action)
      heapOpsPkg::push: slot = currentSize[heapConfigPkg::indexBits-1:0];  // One past end
      heapOpsPkg::pop:  slot = heapConfigPkg::elementIndex'(currentSize - 1'b1); // Last one
      default:          slot = index;
    endcase
  end

  always_comb begin
    case (action)
      heapOpsPkg::add, heapOpsPkg::addAfter:      update = heapOpsPkg::opAdd;
      heapOpsPkg::subtract, heapOpsPkg::subAfter: update = heapOpsPkg::opSubtract;
      heapOpsPkg::bitAnd:                         update = heapOpsPkg::opAnd;
      heapOpsPkg::bitOr:                          update = heapOpsPkg::opOr;
      heapOpsPkg::bitXor:                         update = heapOpsPkg::opXor;
      default:                                    update = heapOpsPkg::opStore;
    endcase
  end

  // --------------------
  // Result registers
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      dataOut   <= '0;
      errorCode <= heapOpsPkg::none;
    end else begin
      errorCode <= checkError;
      if (accepted) begin
        case (action)
          heapOpsPkg::write: dataOut <= dataIn;             // Echo
          heapOpsPkg::read, heapOpsPkg::pop,
          heapOpsPkg::addAfter, heapOpsPkg::subAfter: dataOut <= oldValue;
          heapOpsPkg::size:  dataOut <= heapConfigPkg::elementData'(currentSize);
          heapOpsPkg::alloc: dataOut <= heapConfigPkg::elementData'(grantId);
          heapOpsPkg::add, heapOpsPkg::subtract, heapOpsPkg::bitAnd,
          heapOpsPkg::bitOr, heapOpsPkg::bitXor: dataOut <= newValue;
          default: ;                                        // Free and push hold
        endcase
      end
    end
  end

endmodule

//--- heapModel.svh
/*
  Reference model of the array heap with its flags, free stack,
  fresh counter, sizes and elements, and the rules for one command
*/
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

  bit                        allocated [heapConfigPkg::arrayCount]; // Claimed arrays
  heapConfigPkg::arrayNumber freeStack [$];                         // Back is the top
  int                        freshCount;                            // Numbers used so far
  int                        sizes [heapConfigPkg::arrayCount];
  heapConfigPkg::elementData elements [heapConfigPkg::arrayCount][heapConfigPkg::arrayLength];
  heapConfigPkg::elementData expectData;                            // Expected result
  heapOpsPkg::heapError      expectError;                           // Expected error

  // Hardware reset leaves the elements alone like the RTL memory
  function automatic void resetModel();
    for (int i = 0; i < heapConfigPkg::arrayCount; i++) begin
      allocated[i] = 1'b0;
      sizes[i]     = 0;
    end
    freshCount  = 0;
    freeStack.delete();
    expectData  = '0;
    expectError = heapOpsPkg::none;
  endfunction

  // Applies one command to the state left by the previous one
  function automatic void applyCommand(heapOpsPkg::heapAction action,
                                       heapConfigPkg::arrayNumber arrayId,
                                       heapConfigPkg::elementIndex index,
                                       heapConfigPkg::elementData dataIn);
    int                        sz;
    heapConfigPkg::arrayNumber granted;
    heapConfigPkg::elementData old;
    heapConfigPkg::elementData upd;
    sz          = sizes[arrayId];
    old         = elements[arrayId][index];
    expectError = heapOpsPkg::none;
    if (action == heapOpsPkg::idle) return;
    if (action == heapOpsPkg::alloc) begin
      if (freeStack.size() > 0) begin
        granted = freeStack.pop_back();                     // Most recently freed first
      end else if (freshCount < heapConfigPkg::arrayCount) begin
        granted    = heapConfigPkg::arrayNumber'(freshCount);
        freshCount = freshCount + 1;
      end else begin
        expectError = heapOpsPkg::outOfMemory;
        return;
      end
      allocated[granted] = 1'b1;
      sizes[granted]     = 0;
      expectData         = heapConfigPkg::elementData'(granted);
      return;
    end
    if (!allocated[arrayId]) begin
      expectError = heapOpsPkg::notAllocated;
      return;
    end
    case (action)
      heapOpsPkg::write: begin
        elements[arrayId][index] = dataIn;
        if (index >= sz) sizes[arrayId] = index + 1;
        expectData = dataIn;
      end
      heapOpsPkg::read: begin
        if (index >= sz) expectError = heapOpsPkg::outOfBounds;
        else expectData = old;
      end
      heapOpsPkg::size: expectData = heapConfigPkg::elementData'(sz);
      heapOpsPkg::push: begin
        if (sz == heapConfigPkg::arrayLength) begin
          expectError = heapOpsPkg::arrayFull;
        end else begin
          elements[arrayId][sz] = dataIn;
          sizes[arrayId]        = sz + 1;
        end
      end
      heapOpsPkg::pop: begin
        if (sz == 0) begin
          expectError = heapOpsPkg::arrayEmpty;
        end else begin
          sizes[arrayId] = sz - 1;
          expectData     = elements[arrayId][sz-1];
        end
      end
      heapOpsPkg::free: begin
        allocated[arrayId] = 1'b0;
        freeStack.push_back(arrayId);
      end
      default: begin                                        // In-place updates
        if (index >= sz) begin
          expectError = heapOpsPkg::outOfBounds;
          return;
        end
        case (action)
          heapOpsPkg::add, heapOpsPkg::addAfter:      upd = old + dataIn;
          heapOpsPkg::subtract, heapOpsPkg::subAfter: upd = old - dataIn;
          heapOpsPkg::bitAnd:                         upd = old & dataIn;
          heapOpsPkg::bitOr:                          upd = old | dataIn;
          default:                                    upd = old ^ dataIn;
        endcase
        elements[arrayId][index] = upd;
        expectData = (action inside {heapOpsPkg::addAfter, heapOpsPkg::subAfter}) ? old : upd;
      end
    endcase
  endfunction

`endif

//--- heapTb.sv
`timescale 1ns/1ns
/*
  Testbench for the array heap. Drives a weighted random command
  stream and checks every result against the reference model
*/

module heapTb;

  localparam int commandCount  = 3000;
  localparam int timeoutCycles = commandCount + 100;        // Reset plus drain margin
  localparam int clockPeriod   = 4;

  logic                       clock;
  logic                       reset;
  heapOpsPkg::heapAction      action;
  heapConfigPkg::arrayNumber  arrayId;
  heapConfigPkg::elementIndex index;
  heapConfigPkg::elementData  dataIn;
  heapConfigPkg::elementData  dataOut;
  heapOpsPkg::heapError       errorCode;
  string                      lastCommand;                  // For error lines
  int                         cycleCount = 0;

  // Reference copy of the heap
  `include "heapModel.svh"

  heapMemory heapMemory_inst (
    .clock     (clock),
    .reset     (reset),
    .action    (action),
    .arrayId   (arrayId),
    .index     (index),
    .dataIn    (dataIn),
    .dataOut   (dataOut),
    .errorCode (errorCode)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // --------------------
  // Run limit
  always @(posedge clock) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("Finished with errors");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // --------------------
  // Stimulus choices
  function automatic heapOpsPkg::heapAction pickAction();
    int roll;
    roll = $urandom_range(0, 99);
    if (roll < 5) return heapOpsPkg::idle;
    if (roll < 12) return heapOpsPkg::alloc;
    if (roll < 16) return heapOpsPkg::free;                 // Fewer frees keeps arrays alive
    if (roll < 28) return heapOpsPkg::write;
    if (roll < 40) return heapOpsPkg::read;
    if (roll < 46) return heapOpsPkg::size;
    if (roll < 60) return heapOpsPkg::push;
    if (roll < 70) return heapOpsPkg::pop;
    case ($urandom_range(0, 6))
      0:       return heapOpsPkg::add;
      1:       return heapOpsPkg::addAfter;
      2:       return heapOpsPkg::subtract;
      3:       return heapOpsPkg::subAfter;
      4:       return heapOpsPkg::bitAnd;
      5:       return heapOpsPkg::bitOr;
      default: return heapOpsPkg::bitXor;
    endcase
  endfunction

  // Mostly a live array, sometimes any array for misuse
  function automatic heapConfigPkg::arrayNumber pickArray();
    heapConfigPkg::arrayNumber live [$];
    for (int i = 0; i < heapConfigPkg::arrayCount; i++) begin
      if (allocated[i]) live.push_back(heapConfigPkg::arrayNumber'(i));
    end
    if (live.size() > 0 && $urandom_range(0, 99) < 80) begin
      return live[$urandom_range(0, live.size() - 1)];
    end
    return heapConfigPkg::arrayNumber'($urandom_range(0, heapConfigPkg::arrayCount - 1));
  endfunction

  function automatic heapConfigPkg::elementIndex pickIndex();
    if ($urandom_range(0, 99) < 70) begin
      return heapConfigPkg::elementIndex'($urandom_range(0, 3));  // Small ones mostly
    end
    return heapConfigPkg::elementIndex'($urandom_range(0, heapConfigPkg::arrayLength - 1));
  endfunction

  // --------------------
  // Drive one command and advance the model
  task automatic driveCommand();
    action  = pickAction();
    arrayId = pickArray();
    index   = pickIndex();
    dataIn  = heapConfigPkg::elementData'($urandom);
    applyCommand(action, arrayId, index, dataIn);
    lastCommand = $sformatf("%s array %0d index %0d data %h",
                            action.name(), arrayId, index, dataIn);
  endtask

  // Outputs are stable at the falling edge
  task automatic checkOutputs();
    assert (errorCode === expectError) else begin
      $display("Fail at %0t: %s gave errorCode %h, expected %s", $time, lastCommand,
               errorCode, expectError.name());
      $display("Finished with errors");
      $fatal(1, "errorCode mismatch");
    end
    assert (dataOut === expectData) else begin
      $display("Fail at %0t: %s gave dataOut %h, expected %h", $time, lastCommand,
               dataOut, expectData);
      $display("Finished with errors");
      $fatal(1, "dataOut mismatch");
    end
  endtask

  // --------------------
  // Main sequence
  initial begin
    void'($urandom(32'h59eb_df2e));                         // Seed once
    reset   = 1'b0;
    action  = heapOpsPkg::idle;
    arrayId = '0;
    index   = '0;
    dataIn  = '0;
    resetModel();
    lastCommand = "reset";
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    checkOutputs();                                         // Values after reset
    repeat (commandCount) begin
      driveCommand();
      @(negedge clock);
      checkOutputs();
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
heapConfigPkg.sv
heapOpsPkg.sv
arrayAllocator.sv
arraySizeTable.sv
elementStore.sv
heapMemory.sv
heapTb.sv
